// File: all.f
rtl/scalar_pkg.sv
rtl/scalar_alu.sv
rtl/ldst_unit.sv
rtl/exec_unit_s.sv
rtl/data_bank.sv
rtl/scalar_exec_top.sv
verif/tb_scalar_props.sv
verif/tb_scalar.sv

// File: rtl/data_bank.sv
/*
 * Data bank
 * Word memory with one access in flight; the grant delay steps
 * through 1 to BANK_LAT_MAX cycles on each accepted access.
 */
`default_nettype none

module data_bank (
	input  wire                       clock,
	input  wire                       rst,
	input  wire scalar_pkg::mem_req_t mem_req,
	output scalar_pkg::mem_rsp_t      mem_rsp
);
	import scalar_pkg::*;

	data_t mem [BANK_WORDS];
	data_t rdata_q;
	logic  busy;
	lat_t  cnt;                                         // Cycles left to grant
	lat_t  lat_nxt;                                     // Delay for the next access
	logic  accept;

	assign accept = mem_req.valid && !busy;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy    <= 1'b0;
			cnt     <= '0;
			lat_nxt <= lat_t'(1);
		end else if (accept) begin
			busy    <= 1'b1;
			cnt     <= lat_nxt;
			lat_nxt <= (lat_nxt == lat_t'(BANK_LAT_MAX)) ? lat_t'(1) : lat_nxt + 1'b1;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
			if (cnt == lat_t'(1)) begin
				busy <= 1'b0;                           // Grant cycle ends the access
			end
		end
	end

	// Access done at accept; only one is in flight so data stays valid
	always_ff @(posedge clock) begin
		if (accept) begin
			if (mem_req.write) begin
				mem[mem_req.addr] <= mem_req.wdata;
			end else begin
				rdata_q <= mem[mem_req.addr];
			end
		end
	end

	assign mem_rsp = '{ready: !busy, grant: busy && cnt == lat_t'(1), rdata: rdata_q};

endmodule

`default_nettype wire

// File: rtl/exec_unit_s.sv
/*
 * Scalar execution unit
 * Numbers and routes issued commands to the ALU or to the even/odd
 * load/store unit, and writes back the oldest pending result.
 */
`default_nettype none

module exec_unit_s (
	input  wire                       clock,
	input  wire                       rst,
	input  wire                       issue_valid,
	input  wire scalar_pkg::command_t issue_cmd,
	output logic                      issue_ready,
	output scalar_pkg::mem_req_t      mem_req_evn,
	input  wire scalar_pkg::mem_rsp_t mem_rsp_evn,
	output scalar_pkg::mem_req_t      mem_req_odd,
	input  wire scalar_pkg::mem_rsp_t mem_rsp_odd,
	output scalar_pkg::wb_t           wb,
	output logic                      st_done_evn,
	output logic                      st_done_odd,
	output logic                      cond,
	output logic                      cond_valid
);
	import scalar_pkg::*;

	issue_no_t issue_cnt;
	logic      take_cmd;
	logic      is_alu;
	addr_t     ea;                                      // Effective word address
	logic      bank_sel;
	token_t    cmd_tok;

	logic      alu_req;
	logic      alu_busy;
	logic      alu_pend;
	logic      alu_take;
	data_t     alu_data;
	token_t    alu_tok;

	logic      ls_req   [2];
	logic      ls_busy  [2];
	logic      ls_pend  [2];
	logic      ls_take  [2];
	data_t     ls_data  [2];
	token_t    ls_tok   [2];

	issue_no_t age_alu;
	issue_no_t age_ls   [2];
	issue_no_t age_ls_win;
	logic      ls_any;
	logic      ls_odd_win;
	token_t    wb_tok;
	data_t     wb_data;

	//////////////////////////////
	// Issue and routing
	//////////////////////////////
	assign is_alu      = issue_cmd.cls == OP_ALU;
	assign ea          = issue_cmd.src1[ADDR_W-1:0] + issue_cmd.src2[ADDR_W-1:0];
	assign bank_sel    = ea[0];
	assign issue_ready = is_alu ? !alu_busy : !ls_busy[bank_sel];
	assign take_cmd    = issue_valid && issue_ready;
	assign cmd_tok     = '{dst: issue_cmd.dst, issue_no: issue_cnt};

	assign alu_req   = take_cmd && is_alu;
	assign ls_req[0] = take_cmd && !is_alu && !bank_sel;
	assign ls_req[1] = take_cmd && !is_alu && bank_sel;

	always_ff @(posedge clock) begin
		if (rst) begin
			issue_cnt <= '0;
		end else if (take_cmd) begin
			issue_cnt <= issue_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// Oldest-first write-back
	//////////////////////////////
	assign age_alu    = issue_cnt - alu_tok.issue_no;
	assign age_ls[0]  = issue_cnt - ls_tok[0].issue_no;
	assign age_ls[1]  = issue_cnt - ls_tok[1].issue_no;

	assign ls_any     = ls_pend[0] || ls_pend[1];
	assign ls_odd_win = ls_pend[1] && (!ls_pend[0] || age_ls[1] > age_ls[0]); // Tie to even
	assign age_ls_win = ls_odd_win ? age_ls[1] : age_ls[0];

	assign alu_take   = alu_pend && (!ls_any || age_alu > age_ls_win);
	assign ls_take[1] = !alu_take && ls_odd_win;
	assign ls_take[0] = !alu_take && ls_pend[0] && !ls_odd_win;

	assign wb_tok  = alu_take ? alu_tok : (ls_odd_win ? ls_tok[1] : ls_tok[0]);
	assign wb_data = alu_take ? alu_data : (ls_odd_win ? ls_data[1] : ls_data[0]);
	assign wb      = '{valid: alu_pend || ls_any, dst: wb_tok.dst, data: wb_data,
		issue_no: wb_tok.issue_no};

	scalar_alu i_alu (
		.clock      (clock),
		.rst        (rst),
		.req        (alu_req),
		.op         (issue_cmd.alu_op),
		.src1       (issue_cmd.src1),
		.src2       (issue_cmd.src2),
		.tok        (cmd_tok),
		.take       (alu_take),
		.busy       (alu_busy),
		.pend       (alu_pend),
		.res_data   (alu_data),
		.res_tok    (alu_tok),
		.cond       (cond),
		.cond_valid (cond_valid)
	);

	ldst_unit i_ldst_evn (
		.clock    (clock),
		.rst      (rst),
		.req      (ls_req[0]),
		.op       (issue_cmd.ldst_op),
		.addr     (ea[ADDR_W-1:1]),
		.st_data  (issue_cmd.src3),
		.tok      (cmd_tok),
		.take     (ls_take[0]),
		.mem_rsp  (mem_rsp_evn),
		.busy     (ls_busy[0]),
		.mem_req  (mem_req_evn),
		.pend     (ls_pend[0]),
		.res_data (ls_data[0]),
		.res_tok  (ls_tok[0]),
		.st_done  (st_done_evn)
	);

	ldst_unit i_ldst_odd (
		.clock    (clock),
		.rst      (rst),
		.req      (ls_req[1]),
		.op       (issue_cmd.ldst_op),
		.addr     (ea[ADDR_W-1:1]),
		.st_data  (issue_cmd.src3),
		.tok      (cmd_tok),
		.take     (ls_take[1]),
		.mem_rsp  (mem_rsp_odd),
		.busy     (ls_busy[1]),
		.mem_req  (mem_req_odd),
		.pend     (ls_pend[1]),
		.res_data (ls_data[1]),
		.res_tok  (ls_tok[1]),
		.st_done  (st_done_odd)
	);

endmodule

`default_nettype wire

// File: rtl/ldst_unit.sv
/*
 * Load/store sequencer for one data bank
 * Presents a request until the bank is ready, waits for grant, then
 * holds load data for write-back or reports a finished store.
 */
`default_nettype none

module ldst_unit (
	input  wire                         clock,
	input  wire                         rst,
	input  wire                         req,        // Command taken this cycle
	input  wire scalar_pkg::ldst_op_e   op,
	input  wire scalar_pkg::bank_addr_t addr,
	input  wire scalar_pkg::data_t      st_data,
	input  wire scalar_pkg::token_t     tok,
	input  wire                         take,       // Load data written back
	input  wire scalar_pkg::mem_rsp_t   mem_rsp,
	output logic                        busy,
	output scalar_pkg::mem_req_t        mem_req,
	output logic                        pend,
	output scalar_pkg::data_t           res_data,
	output scalar_pkg::token_t          res_tok,
	output logic                        st_done
);
	import scalar_pkg::*;

	typedef enum logic [1:0] {IDLE, REQ, WAIT, HOLD} state_e;

	state_e     state;
	state_e     state_nxt;
	ldst_op_e   op_q;
	bank_addr_t addr_q;
	data_t      wdata_q;
	logic       accept;
	logic       granted;
	logic       is_load;

	assign accept  = req && (state == IDLE || (state == HOLD && take));
	assign granted = state == WAIT && mem_rsp.grant;
	assign is_load = op_q == LOAD;

	//////////////////////////////
	// Sequencer
	//////////////////////////////
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_nxt = REQ;
				end
			end
			REQ: begin
				if (mem_rsp.ready) begin                    // Bank takes it this cycle
					state_nxt = WAIT;
				end
			end
			WAIT: begin
				if (mem_rsp.grant) begin
					state_nxt = is_load ? HOLD : IDLE;
				end
			end
			HOLD: begin
				if (accept) begin
					state_nxt = REQ;                        // Back to back with write-back
				end else if (take) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state   <= IDLE;
			st_done <= 1'b0;
		end else begin
			state   <= state_nxt;
			st_done <= granted && !is_load;
		end
	end

	// Command and result payload
	always_ff @(posedge clock) begin
		if (accept) begin
			op_q    <= op;
			addr_q  <= addr;
			wdata_q <= st_data;
			res_tok <= tok;
		end
		if (granted && is_load) begin
			res_data <= mem_rsp.rdata;
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////
	assign pend    = state == HOLD;
	assign busy    = state != IDLE && !(state == HOLD && take);
	assign mem_req = '{valid: state == REQ, write: op_q == STORE, addr: addr_q,
		wdata: wdata_q};

endmodule

`default_nettype wire

// File: rtl/scalar_alu.sv
/*
 * Scalar integer ALU
 * One stage of arithmetic and logic, result held with its token until
 * the write-back selector takes it. SLT also drives the condition flag.
 */
`default_nettype none

module scalar_alu (
	input  wire                      clock,
	input  wire                      rst,
	input  wire                      req,           // Command taken this cycle
	input  wire scalar_pkg::alu_op_e op,
	input  wire scalar_pkg::data_t   src1,
	input  wire scalar_pkg::data_t   src2,
	input  wire scalar_pkg::token_t  tok,
	input  wire                      take,          // Held result written back
	output logic                     busy,
	output logic                     pend,
	output scalar_pkg::data_t        res_data,
	output scalar_pkg::token_t       res_tok,
	output logic                     cond,
	output logic                     cond_valid
);
	import scalar_pkg::*;

	data_t alu_res;
	logic  slt_bit;
	logic  load_res;
	logic  is_slt;

	assign slt_bit = $signed(src1) < $signed(src2);
	assign is_slt  = op == SLT;

	always_comb begin
		case (op)
			ADD: begin
				alu_res = src1 + src2;
			end
			SUB: begin
				alu_res = src1 - src2;
			end
			AND: begin
				alu_res = src1 & src2;
			end
			OR: begin
				alu_res = src1 | src2;
			end
			XOR: begin
				alu_res = src1 ^ src2;
			end
			SLL: begin
				alu_res = src1 << src2[$clog2(DATA_W)-1:0];
			end
			SRL: begin
				alu_res = src1 >> src2[$clog2(DATA_W)-1:0];
			end
			SLT: begin
				alu_res = {{(DATA_W-1){1'b0}}, slt_bit};
			end
			default: begin
				alu_res = '0;
			end
		endcase
	end

	// A new result may replace one that leaves this cycle
	assign load_res = req && (!pend || take);
	assign busy     = pend && !take;

	always_ff @(posedge clock) begin
		if (rst) begin
			pend <= 1'b0;
		end else if (load_res) begin
			pend <= 1'b1;
		end else if (take) begin
			pend <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (load_res) begin
			res_data <= alu_res;
			res_tok  <= tok;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			cond       <= 1'b0;
			cond_valid <= 1'b0;
		end else begin
			cond_valid <= load_res && is_slt;               // One cycle, with pend rising
			if (load_res && is_slt) begin
				cond <= slt_bit;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/scalar_exec_top.sv
/*
 * Scalar execution stage top
 * Execution unit with its even and odd data banks.
 */
`default_nettype none

module scalar_exec_top (
	input  wire                       clock,
	input  wire                       rst,
	input  wire                       issue_valid,
	input  wire scalar_pkg::command_t issue_cmd,
	output wire                       issue_ready,
	output wire scalar_pkg::wb_t      wb,
	output wire                       st_done_evn,
	output wire                       st_done_odd,
	output wire                       cond,
	output wire                       cond_valid
);
	import scalar_pkg::*;

	mem_req_t req_evn;                                  // Even word addresses
	mem_rsp_t rsp_evn;
	mem_req_t req_odd;                                  // Odd word addresses
	mem_rsp_t rsp_odd;

	exec_unit_s u_exec (
		.clock       (clock),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_cmd   (issue_cmd),
		.issue_ready (issue_ready),
		.mem_req_evn (req_evn),
		.mem_rsp_evn (rsp_evn),
		.mem_req_odd (req_odd),
		.mem_rsp_odd (rsp_odd),
		.wb          (wb),
		.st_done_evn (st_done_evn),
		.st_done_odd (st_done_odd),
		.cond        (cond),
		.cond_valid  (cond_valid)
	);

	data_bank u_bank_evn (
		.clock   (clock),
		.rst     (rst),
		.mem_req (req_evn),
		.mem_rsp (rsp_evn)
	);

	data_bank u_bank_odd (
		.clock   (clock),
		.rst     (rst),
		.mem_req (req_odd),
		.mem_rsp (rsp_odd)
	);

endmodule

`default_nettype wire

// File: rtl/scalar_pkg.sv
/*
 * Scalar execution stage shared definitions
 * Sizes, opcode enums and the packed structs that carry commands,
 * write-back results and bank traffic between the blocks.
 */
`default_nettype none

package scalar_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////
	localparam int DATA_W       = 32;
	localparam int INDEX_W      = 5;
	localparam int ISSUE_W      = 6;                        // Ages wrap modulo 64
	localparam int ADDR_W       = 8;                        // Word address, both banks
	localparam int BANK_AW      = ADDR_W - 1;               // Low bit picks the bank
	localparam int BANK_WORDS   = 1 << BANK_AW;
	localparam int BANK_LAT_MAX = 3;
	localparam int LAT_W        = $clog2(BANK_LAT_MAX + 1);

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [ISSUE_W-1:0] issue_no_t;
	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [BANK_AW-1:0] bank_addr_t;
	typedef logic [LAT_W-1:0]   lat_t;

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	typedef enum logic {OP_ALU, OP_LDST} op_class_e;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLL, SRL, SLT} alu_op_e;

	typedef enum logic {LOAD, STORE} ldst_op_e;

	//////////////////////////////
	// Bundles
	//////////////////////////////
	typedef struct packed {
		op_class_e cls;
		alu_op_e   alu_op;
		ldst_op_e  ldst_op;
		index_t    dst;
		data_t     src1;
		data_t     src2;
		data_t     src3;                                    // Store data
	} command_t;

	typedef struct packed {
		index_t    dst;
		issue_no_t issue_no;
	} token_t;

	typedef struct packed {
		logic      valid;
		index_t    dst;
		data_t     data;
		issue_no_t issue_no;
	} wb_t;

	typedef struct packed {
		logic       valid;
		logic       write;
		bank_addr_t addr;
		data_t      wdata;
	} mem_req_t;

	typedef struct packed {
		logic  ready;
		logic  grant;
		data_t rdata;                                       // Valid with grant on a load
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_scalar -f all.f \
	--Mdir build -o sim_tb_scalar

./build/sim_tb_scalar > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0

// File: verif/tb_scalar.sv
/*
 * Scalar execution stage testbench
 * Directed and random commands, a shadow memory and result table,
 * oldest-first write-back and store completion checks.
 */
`default_nettype none

module tb_scalar;
	import scalar_pkg::*;

	localparam int TIMEOUT = 300 * (BANK_LAT_MAX + 2) * 2;

	logic     clock;
	logic     rst;
	logic     issue_valid;
	command_t issue_cmd;
	wire      issue_ready;
	wb_t      wb;
	wire      st_done_evn;
	wire      st_done_odd;
	wire      cond;
	wire      cond_valid;

	data_t     shadow [256];
	bit        written [256];                           // Generator side
	bit        out_valid [64];
	index_t    out_dst [64];
	data_t     out_data [64];
	int        out_cyc [64];
	bit        out_alu [64];
	int        outstanding;
	int        st_evn;
	int        st_odd;
	int        issued;
	int        cyc;
	issue_no_t tb_cnt;
	issue_no_t age_w;
	issue_no_t age_i;
	logic      slt_exp;
	logic      slt_due;                                 // SLT taken, flag due next cycle
	addr_t     ea;
	integer    seed;

	scalar_exec_top dut (
		.clock       (clock),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_cmd   (issue_cmd),
		.issue_ready (issue_ready),
		.wb          (wb),
		.st_done_evn (st_done_evn),
		.st_done_odd (st_done_odd),
		.cond        (cond),
		.cond_valid  (cond_valid)
	);

	bind exec_unit_s tb_scalar_props u_props (
		.clock    (clock),
		.rst      (rst),
		.req_evn  (mem_req_evn),
		.rsp_evn  (mem_rsp_evn),
		.req_odd  (mem_req_odd),
		.rsp_odd  (mem_rsp_odd),
		.alu_take (alu_take),
		.take_evn (ls_take[0]),
		.take_odd (ls_take[1])
	);

	always #4 clock = !clock;

	function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			SLL: return a << b[4:0];
			SRL: return a >> b[4:0];
			default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	task automatic show_mismatch(input string name, input data_t exp, input data_t act);
		$display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
		$display("sim failed");
	endtask

	task automatic show_failure(input string what);
		$display("t=%0t %s", $time, what);
		$display("sim failed");
	endtask

	//////////////////////////////
	// Monitor and reference model
	//////////////////////////////
	always @(negedge clock) begin
		cyc = cyc + 1;
		if (cyc > TIMEOUT) begin
			show_failure("run did not finish within the cycle limit");
			$fatal(1);
		end
		if (issued == 0 && cyc > 1) begin                   // Reset and idle values
			assert (!wb.valid && !st_done_evn && !st_done_odd && !cond_valid && issue_ready)
			else begin
				show_failure("outputs not idle around reset");
				$fatal(1);
			end
		end
		if (!rst && wb.valid) begin
			assert (out_valid[wb.issue_no]) else begin
				show_failure("write-back of an unknown or repeated issue number");
				$fatal(1);
			end
			assert (wb.data == out_data[wb.issue_no]) else begin
				show_mismatch("wb.data", out_data[wb.issue_no], wb.data);
				$fatal(1);
			end
			assert (wb.dst == out_dst[wb.issue_no]) else begin
				show_mismatch("wb.dst", data_t'(out_dst[wb.issue_no]), data_t'(wb.dst));
				$fatal(1);
			end
			age_w = tb_cnt - wb.issue_no;
			for (int i = 0; i < 64; i++) begin
				age_i = tb_cnt - issue_no_t'(i);
				if (out_valid[i] && age_i > age_w &&
						cyc - out_cyc[i] >= (out_alu[i] ? 1 : BANK_LAT_MAX + 2)) begin
					show_mismatch("wb.issue_no", data_t'(i), data_t'(wb.issue_no));
					$fatal(1);
				end
			end
			out_valid[wb.issue_no] = 1'b0;
			outstanding = outstanding - 1;
		end
		if (!rst) begin
			assert (cond_valid == slt_due) else begin
				show_mismatch("cond_valid", data_t'(slt_due), data_t'(cond_valid));
				$fatal(1);
			end
		end
		if (!rst && cond_valid) begin
			assert (cond == slt_exp) else begin
				show_mismatch("cond", data_t'(slt_exp), data_t'(cond));
				$fatal(1);
			end
		end
		slt_due = 1'b0;
		if (!rst && st_done_evn) begin
			assert (st_evn > 0) else begin
				show_failure("extra st_done on the even side");
				$fatal(1);
			end
			st_evn = st_evn - 1;
		end
		if (!rst && st_done_odd) begin
			assert (st_odd > 0) else begin
				show_failure("extra st_done on the odd side");
				$fatal(1);
			end
			st_odd = st_odd - 1;
		end
		if (!rst && issue_valid && issue_ready) begin       // Taken at the next edge
			ea = issue_cmd.src1[7:0] + issue_cmd.src2[7:0];
			if (issue_cmd.cls == OP_LDST && issue_cmd.ldst_op == STORE) begin
				shadow[ea] = issue_cmd.src3;
				if (ea[0]) begin
					st_odd = st_odd + 1;
				end else begin
					st_evn = st_evn + 1;
				end
			end else begin
				out_valid[tb_cnt] = 1'b1;
				out_dst[tb_cnt]   = issue_cmd.dst;
				out_cyc[tb_cnt]   = cyc;
				out_alu[tb_cnt]   = issue_cmd.cls == OP_ALU;
				if (issue_cmd.cls == OP_ALU) begin
					out_data[tb_cnt] = alu_model(issue_cmd.alu_op, issue_cmd.src1, issue_cmd.src2);
					if (issue_cmd.alu_op == SLT) begin
						slt_exp = out_data[tb_cnt][0];
						slt_due = 1'b1;
					end
				end else begin
					out_data[tb_cnt] = shadow[ea];
				end
				outstanding = outstanding + 1;
			end
			tb_cnt = tb_cnt + 1'b1;
			issued = issued + 1;
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic send(input command_t c);
		issue_valid <= 1'b1;
		issue_cmd   <= c;
		@(negedge clock);
		while (!issue_ready) begin                          // Hold under back-pressure
			@(negedge clock);
		end
		@(posedge clock);
		issue_valid <= 1'b0;
	endtask

	function automatic command_t ldst_cmd(input ldst_op_e op, input data_t base,
			input addr_t addr, input data_t sdata, input index_t dst);
		command_t c;
		c         = '0;
		c.cls     = OP_LDST;
		c.ldst_op = op;
		c.dst     = dst;
		c.src1    = base;
		c.src2    = {base[31:8] ^ 24'h5a5a5a, addr - base[7:0]};
		c.src3    = sdata;
		written[addr] = 1'b1;
		return c;
	endfunction

	function automatic command_t alu_cmd(input alu_op_e op, input data_t a, input data_t b,
			input index_t dst);
		command_t c;
		c        = '0;
		c.cls    = OP_ALU;
		c.alu_op = op;
		c.dst    = dst;
		c.src1   = a;
		c.src2   = b;
		return c;
	endfunction

	initial begin
		data_t r;
		data_t r2;
		addr_t a;
		clock = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_cmd = '0;
		seed = 18;
		outstanding = 0;
		st_evn = 0;
		st_odd = 0;
		issued = 0;
		cyc = 0;
		tb_cnt = '0;
		slt_exp = 1'b0;
		slt_due = 1'b0;
		for (int i = 0; i < 256; i++) begin
			written[i] = 1'b0;
			shadow[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			out_valid[i] = 1'b0;
		end
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		// Directed stores then loads, both banks
		for (int i = 0; i < 8; i++) begin
			send(ldst_cmd(STORE, 32'h100 * i, addr_t'(i), 32'hc0de0000 + i, index_t'(i)));
		end
		for (int i = 0; i < 8; i++) begin
			send(ldst_cmd(LOAD, 32'h33, addr_t'(i), '0, index_t'(i + 8)));
		end
		for (int i = 0; i < 4; i++) begin                   // Same bank back to back
			send(ldst_cmd(LOAD, 32'h7, addr_t'(2 * i), '0, index_t'(i + 16)));
		end
		send(alu_cmd(SLT, 32'hffff_fff0, 32'd3, 5'd20));
		send(alu_cmd(SLT, 32'd9, 32'd3, 5'd21));
		send(alu_cmd(SUB, 32'd5, 32'd9, 5'd22));
		// Random part
		for (int k = 0; k < 200; k++) begin
			r  = $random(seed);
			r2 = $random(seed);
			a  = {3'b000, r[12:8]};
			if (r[0]) begin
				send(alu_cmd(alu_op_e'(r[3:1]), r2, {r[31:16], r[7:0], r[15:8]},
					index_t'(r[20:16])));
			end else if (r[1] || !written[a]) begin
				send(ldst_cmd(STORE, r2, a, {r2[15:0], r[31:16]}, index_t'(r[20:16])));
			end else begin
				send(ldst_cmd(LOAD, r2, a, '0, index_t'(r[20:16])));
			end
		end
		while (outstanding != 0 || st_evn != 0 || st_odd != 0) begin
			@(negedge clock);
		end
		repeat (4) @(negedge clock);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tb_scalar_props.sv
/*
 * Execution unit protocol properties
 * Bank request hold, grant only with an access in flight, and a
 * single write-back take per cycle.
 */
`default_nettype none

module tb_scalar_props (
	input wire                       clock,
	input wire                       rst,
	input wire scalar_pkg::mem_req_t req_evn,
	input wire scalar_pkg::mem_rsp_t rsp_evn,
	input wire scalar_pkg::mem_req_t req_odd,
	input wire scalar_pkg::mem_rsp_t rsp_odd,
	input wire                       alu_take,
	input wire                       take_evn,
	input wire                       take_odd
);
	import scalar_pkg::*;

	logic fly_evn;                                      // Access accepted, no grant yet
	logic fly_odd;

	always_ff @(posedge clock) begin
		if (rst) begin
			fly_evn <= 1'b0;
			fly_odd <= 1'b0;
		end else begin
			if (req_evn.valid && rsp_evn.ready) begin
				fly_evn <= 1'b1;
			end else if (rsp_evn.grant) begin
				fly_evn <= 1'b0;
			end
			if (req_odd.valid && rsp_odd.ready) begin
				fly_odd <= 1'b1;
			end else if (rsp_odd.grant) begin
				fly_odd <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Properties
	//////////////////////////////
	a_req_hold_evn: assert property (@(posedge clock) disable iff (rst)
		req_evn.valid && !rsp_evn.ready |=> req_evn.valid) else $error("even request dropped");
	a_req_hold_odd: assert property (@(posedge clock) disable iff (rst)
		req_odd.valid && !rsp_odd.ready |=> req_odd.valid) else $error("odd request dropped");
	a_grant_evn: assert property (@(posedge clock) disable iff (rst)
		rsp_evn.grant |-> fly_evn) else $error("even grant without access");
	a_grant_odd: assert property (@(posedge clock) disable iff (rst)
		rsp_odd.grant |-> fly_odd) else $error("odd grant without access");
	a_one_take: assert property (@(posedge clock) disable iff (rst)
		$onehot0({alu_take, take_evn, take_odd})) else $error("more than one take");

endmodule

`default_nettype wire
